// File: verilog.f
axi_pkg.sv
cache_pkg.sv
axi_dcache.sv
dcache_core.sv
dcache_top.sv
tb_axi_mem.sv
tb_checker.sv
tb_dcache_top.sv

// File: run.sh
#!/bin/sh
# build and run; the log decides the outcome
verilator --binary --timing --assert --top-module tb_dcache_top -f verilog.f -o sim \
    > run.log 2>&1 \
    && ./obj_dir/sim >> run.log 2>&1 \
    || echo "Something failed" >> run.log
cat run.log
grep -q "Something failed" run.log && exit 1 || exit 0

// File: tb_dcache_top.sv
module tb_dcache_top
    import axi_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROWS       = 14;
    localparam int WAIT_LIMIT = 500;   // cycles per wait

    typedef logic [95:0] name_t;

    typedef struct packed {
        name_t name;
        logic  write;
        addr_t addr;
        beat_t wdata;
        strb_t strb;
        beat_t exp_data;   // ignored for stores
        logic  hit;        // response due 2 cycles after accept
    } row_t;

    // lines 2 and 13 each get dirtied, evicted by tag 1 and read back
    row_t rows [ROWS] = '{
        '{"ld_miss",    1'b0, 32'h0000_0040, 64'h0, 8'h00, 64'h0000_0000_4040_5040, 1'b0},
        '{"ld_hit",     1'b0, 32'h0000_0048, 64'h0, 8'h00, 64'h0000_0000_4848_5848, 1'b1},
        '{"st_low",     1'b1, 32'h0000_0048, 64'h1122_3344_5566_7788, 8'h0f, 64'h0, 1'b1},
        '{"ld_low",     1'b0, 32'h0000_0048, 64'h0, 8'h00, 64'h0000_0000_5566_7788, 1'b1},
        '{"st_high",    1'b1, 32'h0000_0050, 64'haabb_ccdd_eeff_0011, 8'hf0, 64'h0, 1'b1},
        '{"ld_high",    1'b0, 32'h0000_0050, 64'h0, 8'h00, 64'haabb_ccdd_5050_6050, 1'b1},
        '{"st_bytes",   1'b1, 32'h0000_0058, 64'hffff_ffff_ffff_ffff, 8'h24, 64'h0, 1'b1},
        '{"ld_evict",   1'b0, 32'h0000_0240, 64'h0, 8'h00, 64'h0000_0002_4242_5240, 1'b0},
        '{"ld_back",    1'b0, 32'h0000_0048, 64'h0, 8'h00, 64'h0000_0000_5566_7788, 1'b0},
        '{"ld_back_b",  1'b0, 32'h0000_0058, 64'h0, 8'h00, 64'h0000_ff00_58ff_6858, 1'b1},
        '{"st_miss",    1'b1, 32'h0000_01a0, 64'hdead_beef_0123_4567, 8'hff, 64'h0, 1'b0},
        '{"ld_evict2",  1'b0, 32'h0000_03a0, 64'h0, 8'h00, 64'h0000_0003_a3a3_b3a0, 1'b0},
        '{"ld_back2",   1'b0, 32'h0000_01a0, 64'h0, 8'h00, 64'hdead_beef_0123_4567, 1'b0},
        '{"ld_line_w3", 1'b0, 32'h0000_01b8, 64'h0, 8'h00, 64'h0000_0001_b9b9_c9b8, 1'b1}
    };

    logic  clock;
    logic  reset;
    logic  req_valid;
    logic  req_write;
    addr_t req_addr;
    beat_t req_wdata;
    strb_t req_wstrb;
    logic  req_ready;
    logic  resp_valid;
    beat_t resp_rdata;
    logic  aw_ready, aw_valid, w_ready, w_valid, w_last, b_valid, b_ready;
    logic  ar_ready, ar_valid, r_valid, r_last, r_ready;
    addr_t aw_addr, ar_addr;
    beat_t w_data, r_data;
    strb_t w_strb;
    resp_t b_resp, r_resp;
    name_t cur_name;
    logic  cur_write;
    beat_t cur_data;
    logic  cur_hit;
    int    errors;

    dcache_top dcache_top_i (
        .clock          (clock),
        .reset          (reset),
        .req_valid_i    (req_valid),
        .req_write_i    (req_write),
        .req_addr_i     (req_addr),
        .req_wdata_i    (req_wdata),
        .req_wstrb_i    (req_wstrb),
        .req_ready_o    (req_ready),
        .resp_valid_o   (resp_valid),
        .resp_rdata_o   (resp_rdata),
        .axi_aw_ready_i (aw_ready),
        .axi_aw_valid_o (aw_valid),
        .axi_aw_addr_o  (aw_addr),
        .axi_w_ready_i  (w_ready),
        .axi_w_valid_o  (w_valid),
        .axi_w_data_o   (w_data),
        .axi_w_strb_o   (w_strb),
        .axi_w_last_o   (w_last),
        .axi_b_valid_i  (b_valid),
        .axi_b_resp_i   (b_resp),
        .axi_b_ready_o  (b_ready),
        .axi_ar_ready_i (ar_ready),
        .axi_ar_valid_o (ar_valid),
        .axi_ar_addr_o  (ar_addr),
        .axi_r_valid_i  (r_valid),
        .axi_r_data_i   (r_data),
        .axi_r_last_i   (r_last),
        .axi_r_resp_i   (r_resp),
        .axi_r_ready_o  (r_ready)
    );

    tb_axi_mem mem_i (
        .clock      (clock),
        .aw_valid_i (aw_valid),
        .aw_addr_i  (aw_addr),
        .aw_ready_o (aw_ready),
        .w_valid_i  (w_valid),
        .w_data_i   (w_data),
        .w_strb_i   (w_strb),
        .w_last_i   (w_last),
        .w_ready_o  (w_ready),
        .b_valid_o  (b_valid),
        .b_resp_o   (b_resp),
        .b_ready_i  (b_ready),
        .ar_valid_i (ar_valid),
        .ar_addr_i  (ar_addr),
        .ar_ready_o (ar_ready),
        .r_valid_o  (r_valid),
        .r_data_o   (r_data),
        .r_last_o   (r_last),
        .r_resp_o   (r_resp),
        .r_ready_i  (r_ready)
    );

    tb_checker checker_i (
        .clock        (clock),
        .reset        (reset),
        .req_valid_i  (req_valid),
        .req_ready_i  (req_ready),
        .resp_valid_i (resp_valid),
        .resp_rdata_i (resp_rdata),
        .aw_valid_i   (aw_valid),
        .w_valid_i    (w_valid),
        .w_ready_i    (w_ready),
        .w_last_i     (w_last),
        .w_strb_i     (w_strb),
        .b_ready_i    (b_ready),
        .ar_valid_i   (ar_valid),
        .r_ready_i    (r_ready),
        .exp_name_i   (cur_name),
        .exp_write_i  (cur_write),
        .exp_data_i   (cur_data),
        .exp_hit_i    (cur_hit),
        .errors_o     (errors)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // one request and its response with ok dropping on a timeout
    task automatic apply_row(input row_t row, output logic ok);
        int cycles;
        ok = 1'b1;
        @(posedge clock);
        #2;
        req_valid = 1'b1;
        req_write = row.write;
        req_addr  = row.addr;
        req_wdata = row.wdata;
        req_wstrb = row.strb;
        cur_name  = row.name;
        cur_write = row.write;
        cur_data  = row.exp_data;
        cur_hit   = row.hit;
        cycles = 0;
        @(negedge clock);
        while (!req_ready && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (!req_ready) begin
            $display("timeout in row %0s, the cache never became ready", row.name);
            ok = 1'b0;
            return;
        end
        @(posedge clock);   // accepted here
        #2;
        req_valid = 1'b0;
        cycles = 0;
        @(negedge clock);
        while (!resp_valid && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (!resp_valid) begin
            $display("timeout in row %0s, no response came back", row.name);
            ok = 1'b0;
        end
    endtask

    initial begin
        int   timeouts;
        logic ok;
        timeouts  = 0;
        reset     = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        cur_name  = '0;
        cur_write = 1'b0;
        cur_data  = '0;
        cur_hit   = 1'b0;
        repeat (16) @(posedge clock);
        #2;
        reset = 1'b1;
        for (int i = 0; i < ROWS; i++) begin
            apply_row(rows[i], ok);
            if (!ok) begin
                timeouts++;
                break;
            end
        end
        repeat (2) @(posedge clock);
        $display("errors %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: tb_checker.sv
module tb_checker
    import axi_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          req_valid_i,
    input  logic          req_ready_i,
    input  logic          resp_valid_i,
    input  beat_t         resp_rdata_i,
    input  logic          aw_valid_i,
    input  logic          w_valid_i,
    input  logic          w_ready_i,
    input  logic          w_last_i,
    input  strb_t         w_strb_i,
    input  logic          b_ready_i,
    input  logic          ar_valid_i,
    input  logic          r_ready_i,
    input  logic [95:0]   exp_name_i,   // row name as packed characters
    input  logic          exp_write_i,
    input  beat_t         exp_data_i,
    input  logic          exp_hit_i,
    output int            errors_o
);
    timeunit 1ns;
    timeprecision 100ps;

    int   errors     = 0;
    int   lat        = 0;
    int   w_beats    = 0;
    logic in_flight  = 1'b0;
    logic reset_seen = 1'b0;

    assign errors_o = errors;

    task automatic report_mismatch(input string what, input beat_t exp, input beat_t act);
        errors++;
        $display("[FAIL] %0s %0s expected %0h actual %0h", exp_name_i, what, exp, act);
    endtask

    // all sampling on the falling edge away from DUT updates
    always @(negedge clock) begin
        if (reset && !reset_seen) begin
            reset_seen = 1'b1;
            // ready high with every valid and AXI ready low
            if ({req_ready_i, resp_valid_i, aw_valid_i, w_valid_i, b_ready_i,
                 ar_valid_i, r_ready_i} != 7'b100_0000) begin
                errors++;
                $display("[FAIL] after_reset idle outputs expected %b actual %b",
                         7'b100_0000, {req_ready_i, resp_valid_i, aw_valid_i,
                                       w_valid_i, b_ready_i, ar_valid_i, r_ready_i});
            end
        end
        if (in_flight) lat++;
        if (resp_valid_i) begin
            if (!in_flight) begin
                errors++;
                $display("response pulse came while no request was in flight");
            end else begin
                if (exp_hit_i && lat != 2) begin
                    report_mismatch("latency", 64'd2, beat_t'(lat));
                end
                if (!exp_write_i && resp_rdata_i != exp_data_i) begin
                    report_mismatch("rdata", exp_data_i, resp_rdata_i);
                end
                in_flight = 1'b0;
            end
        end
        if (req_valid_i && req_ready_i) begin
            in_flight = 1'b1;   // accepted on the next rising edge
            lat       = 0;
        end
        if (w_valid_i && w_ready_i) begin
            w_beats++;
            if (w_strb_i != '1) report_mismatch("w_strb", 64'hff, beat_t'(w_strb_i));
            if (w_last_i) begin
                if (w_beats != BEATS_PER_LINE) begin
                    report_mismatch("w_beats", beat_t'(BEATS_PER_LINE), beat_t'(w_beats));
                end
                w_beats = 0;
            end
        end
    end

endmodule

// File: tb_axi_mem.sv
module tb_axi_mem
    import axi_pkg::*;
(
    input  logic  clock,

    input  logic  aw_valid_i,
    input  addr_t aw_addr_i,
    output logic  aw_ready_o,
    input  logic  w_valid_i,
    input  beat_t w_data_i,
    input  strb_t w_strb_i,
    input  logic  w_last_i,
    output logic  w_ready_o,
    output logic  b_valid_o,
    output resp_t b_resp_o,
    input  logic  b_ready_i,

    input  logic  ar_valid_i,
    input  addr_t ar_addr_i,
    output logic  ar_ready_o,
    output logic  r_valid_o,
    output beat_t r_data_o,
    output logic  r_last_o,
    output resp_t r_resp_o,
    input  logic  r_ready_i
);
    timeunit 1ns;
    timeprecision 100ps;

    beat_t       mem [addr_t];   // only words that were written back
    logic [15:0] lfsr;
    addr_t       wr_base;
    addr_t       rd_base;
    int          w_beat;
    int          r_beat;
    logic        r_active;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function logic take_bit();
        lfsr = lfsr_next(lfsr);
        return lfsr[0];
    endfunction

    // contents before any write-back
    function automatic beat_t init_word(input addr_t a);
        return beat_t'(a) * 64'h0000_0000_0101_0101 + 64'h0000_0000_0000_1000;
    endfunction

    function automatic beat_t read_word(input addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return init_word(a);
    endfunction

    initial begin
        logic  aw_fire;
        logic  w_fire;
        logic  b_fire;
        logic  ar_fire;
        logic  r_fire;
        logic  w_last;
        addr_t aw_addr;
        addr_t ar_addr;
        addr_t w_addr;
        beat_t w_data;
        beat_t merged;
        strb_t w_strb;

        lfsr       = 16'd75;
        aw_ready_o = 1'b0;
        w_ready_o  = 1'b0;
        b_valid_o  = 1'b0;
        b_resp_o   = RESP_OKAY;
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_data_o   = '0;
        r_last_o   = 1'b0;
        r_resp_o   = RESP_OKAY;
        r_active   = 1'b0;
        wr_base    = '0;
        rd_base    = '0;
        w_beat     = 0;
        r_beat     = 0;
        forever begin
            @(negedge clock);   // handshakes of the coming edge
            aw_fire = aw_valid_i && aw_ready_o;
            w_fire  = w_valid_i && w_ready_o;
            b_fire  = b_valid_o && b_ready_i;
            ar_fire = ar_valid_i && ar_ready_o;
            r_fire  = r_valid_o && r_ready_i;
            aw_addr = aw_addr_i;
            ar_addr = ar_addr_i;
            w_data  = w_data_i;
            w_strb  = w_strb_i;
            w_last  = w_last_i;
            @(posedge clock);
            #2;
            if (aw_fire) begin
                wr_base = aw_addr;
                w_beat  = 0;
            end
            if (b_fire) b_valid_o = 1'b0;
            if (w_fire) begin
                w_addr = wr_base + addr_t'(8 * w_beat);
                merged = read_word(w_addr);
                for (int b = 0; b < 8; b++) begin
                    if (w_strb[b]) merged[b*8 +: 8] = w_data[b*8 +: 8];
                end
                mem[w_addr] = merged;
                w_beat++;
                if (w_last) b_valid_o = 1'b1;
            end
            if (ar_fire) begin
                rd_base  = ar_addr;
                r_beat   = 0;
                r_active = 1'b1;
            end
            if (r_fire) begin
                r_beat++;
                if (r_beat == BEATS_PER_LINE) r_active = 1'b0;
            end
            aw_ready_o = take_bit();
            w_ready_o  = take_bit();
            ar_ready_o = take_bit();
            if (r_active) begin
                // a beat already offered stays until taken
                if (!(r_valid_o && !r_fire)) r_valid_o = take_bit();
                r_data_o = read_word(rd_base + addr_t'(8 * r_beat));
                r_last_o = (r_beat == BEATS_PER_LINE - 1);
            end else begin
                r_valid_o = 1'b0;
                r_last_o  = 1'b0;
            end
        end
    end

endmodule

// File: dcache_top.sv
module dcache_top
    import axi_pkg::*;
    import cache_pkg::*;
(
    input  logic  clock,
    input  logic  reset,

    input  logic  req_valid_i,
    input  logic  req_write_i,
    input  addr_t req_addr_i,
    input  beat_t req_wdata_i,
    input  strb_t req_wstrb_i,
    output logic  req_ready_o,
    output logic  resp_valid_o,
    output beat_t resp_rdata_o,

    input  logic  axi_aw_ready_i,
    output logic  axi_aw_valid_o,
    output addr_t axi_aw_addr_o,
    input  logic  axi_w_ready_i,
    output logic  axi_w_valid_o,
    output beat_t axi_w_data_o,
    output strb_t axi_w_strb_o,
    output logic  axi_w_last_o,
    input  logic  axi_b_valid_i,
    input  resp_t axi_b_resp_i,
    output logic  axi_b_ready_o,
    input  logic  axi_ar_ready_i,
    output logic  axi_ar_valid_o,
    output addr_t axi_ar_addr_o,
    input  logic  axi_r_valid_i,
    input  beat_t axi_r_data_i,
    input  logic  axi_r_last_i,
    input  resp_t axi_r_resp_i,
    output logic  axi_r_ready_o
);

    // core to bridge
    logic  rd_valid;
    logic  rd_ready;
    addr_t rd_addr;
    logic  rd_beat_valid;
    beat_t rd_data;
    logic  rd_last;
    logic  wr_valid;
    logic  wr_ready;
    addr_t wr_addr;
    line_t wr_line;

    dcache_core dcache_core_i (
        .clock           (clock),
        .reset           (reset),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .req_write_i     (req_write_i),
        .req_addr_i      (req_addr_i),
        .req_wdata_i     (req_wdata_i),
        .req_wstrb_i     (req_wstrb_i),
        .resp_valid_o    (resp_valid_o),
        .resp_rdata_o    (resp_rdata_o),
        .rd_valid_o      (rd_valid),
        .rd_ready_i      (rd_ready),
        .rd_addr_o       (rd_addr),
        .rd_beat_valid_i (rd_beat_valid),
        .rd_data_i       (rd_data),
        .rd_last_i       (rd_last),
        .wr_valid_o      (wr_valid),
        .wr_ready_i      (wr_ready),
        .wr_addr_o       (wr_addr),
        .wr_line_o       (wr_line)
    );

    axi_dcache axi_dcache_i (
        .clock           (clock),
        .reset           (reset),
        .rd_valid_i      (rd_valid),
        .rd_ready_o      (rd_ready),
        .rd_addr_i       (rd_addr),
        .rd_beat_valid_o (rd_beat_valid),
        .rd_data_o       (rd_data),
        .rd_last_o       (rd_last),
        .wr_valid_i      (wr_valid),
        .wr_ready_o      (wr_ready),
        .wr_addr_i       (wr_addr),
        .wr_line_i       (wr_line),
        .axi_aw_ready_i  (axi_aw_ready_i),
        .axi_aw_valid_o  (axi_aw_valid_o),
        .axi_aw_addr_o   (axi_aw_addr_o),
        .axi_w_ready_i   (axi_w_ready_i),
        .axi_w_valid_o   (axi_w_valid_o),
        .axi_w_data_o    (axi_w_data_o),
        .axi_w_strb_o    (axi_w_strb_o),
        .axi_w_last_o    (axi_w_last_o),
        .axi_b_valid_i   (axi_b_valid_i),
        .axi_b_resp_i    (axi_b_resp_i),
        .axi_b_ready_o   (axi_b_ready_o),
        .axi_ar_ready_i  (axi_ar_ready_i),
        .axi_ar_valid_o  (axi_ar_valid_o),
        .axi_ar_addr_o   (axi_ar_addr_o),
        .axi_r_valid_i   (axi_r_valid_i),
        .axi_r_data_i    (axi_r_data_i),
        .axi_r_last_i    (axi_r_last_i),
        .axi_r_resp_i    (axi_r_resp_i),
        .axi_r_ready_o   (axi_r_ready_o)
    );

endmodule

// File: dcache_core.sv
module dcache_core
    import axi_pkg::*;
    import cache_pkg::*;
(
    input  logic  clock,
    input  logic  reset,

    // CPU request and response
    input  logic  req_valid_i,
    output logic  req_ready_o,
    input  logic  req_write_i,
    input  addr_t req_addr_i,
    input  beat_t req_wdata_i,
    input  strb_t req_wstrb_i,
    output logic  resp_valid_o,
    output beat_t resp_rdata_o,

    // refill side of the bridge
    output logic  rd_valid_o,
    input  logic  rd_ready_i,
    output addr_t rd_addr_o,
    input  logic  rd_beat_valid_i,
    input  beat_t rd_data_i,
    input  logic  rd_last_i,

    // write-back side of the bridge
    output logic  wr_valid_o,
    input  logic  wr_ready_i,
    output addr_t wr_addr_o,
    output line_t wr_line_o
);

    ctrl_state_t          state_q, state_d;
    logic [NUM_LINES-1:0] valid_q;
    logic [NUM_LINES-1:0] dirty_q;
    tag_t                 tag_q  [NUM_LINES];
    line_t                data_q [NUM_LINES];

    // the one request in flight
    logic                 req_write_q;
    addr_t                req_addr_q;
    beat_t                req_wdata_q;
    strb_t                req_wstrb_q;
    beat_t                rdata_q;

    word_t                rf_cnt_q;
    tag_t                 req_tag;
    index_t               req_idx;
    word_t                req_word;
    beat_t                cur_word;
    logic                 accept;
    logic                 hit;
    logic                 store_hit;
    logic                 rf_beat;
    logic                 rf_done;

    // byte merge of a store into the stored word
    function automatic beat_t merge_beat(beat_t old_w, beat_t new_w, strb_t strb);
        beat_t merged;
        merged = old_w;
        for (int b = 0; b < STRB_BITS; b++) begin
            if (strb[b]) begin
                merged[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign accept    = req_valid_i && req_ready_o;
    assign req_tag   = req_addr_q[TAG_LSB +: TAG_BITS];
    assign req_idx   = req_addr_q[INDEX_LSB +: INDEX_BITS];
    assign req_word  = req_addr_q[WORD_LSB +: WORD_BITS];
    assign cur_word  = data_q[req_idx][req_word*BEAT_BITS +: BEAT_BITS];
    assign hit       = valid_q[req_idx] && (tag_q[req_idx] == req_tag);
    assign store_hit = (state_q == st_lookup) && hit && req_write_q;
    assign rf_beat   = (state_q == st_rf_wait) && rd_beat_valid_i;
    assign rf_done   = rf_beat && rd_last_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (accept) state_d = st_lookup;
            end
            st_lookup: begin
                if (hit) begin
                    state_d = st_respond;
                end else if (valid_q[req_idx] && dirty_q[req_idx]) begin
                    state_d = st_wb_issue;    // victim must reach memory first
                end else begin
                    state_d = st_rf_issue;
                end
            end
            st_wb_issue: begin
                if (wr_ready_i) state_d = st_wb_wait;
            end
            st_wb_wait: begin
                if (wr_ready_i) state_d = st_rf_issue;  // B response seen
            end
            st_rf_issue: begin
                if (rd_ready_i) state_d = st_rf_wait;
            end
            st_rf_wait: begin
                if (rf_done) state_d = st_lookup;       // replay the access as a hit
            end
            st_respond: begin
                state_d = st_idle;
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q  <= st_idle;
            valid_q  <= '0;
            dirty_q  <= '0;
            rf_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == st_rf_issue) begin
                rf_cnt_q <= '0;
            end else if (rf_beat) begin
                rf_cnt_q <= rf_cnt_q + 1'b1;
            end
            if (rf_done) begin
                valid_q[req_idx] <= 1'b1;
                dirty_q[req_idx] <= 1'b0;   // fresh copy of memory
            end
            if (store_hit) begin
                dirty_q[req_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req_write_q <= req_write_i;
            req_addr_q  <= req_addr_i;
            req_wdata_q <= req_wdata_i;
            req_wstrb_q <= req_wstrb_i;
        end
        // beats arrive in word order from the line base
        if (rf_beat) begin
            data_q[req_idx][rf_cnt_q*BEAT_BITS +: BEAT_BITS] <= rd_data_i;
        end
        if (rf_done) begin
            tag_q[req_idx] <= req_tag;
        end
        if (store_hit) begin
            data_q[req_idx][req_word*BEAT_BITS +: BEAT_BITS] <=
                merge_beat(cur_word, req_wdata_q, req_wstrb_q);
        end else if ((state_q == st_lookup) && hit) begin
            rdata_q <= cur_word;
        end
    end

    assign req_ready_o  = (state_q == st_idle);
    assign resp_valid_o = (state_q == st_respond);
    assign resp_rdata_o = rdata_q;

    assign rd_valid_o   = (state_q == st_rf_issue);
    assign rd_addr_o    = {req_tag, req_idx, {INDEX_LSB{1'b0}}};   // line aligned

    // victim address is rebuilt from its stored tag
    assign wr_valid_o   = (state_q == st_wb_issue);
    assign wr_addr_o    = {tag_q[req_idx], req_idx, {INDEX_LSB{1'b0}}};
    assign wr_line_o    = data_q[req_idx];

    resp_single_pulse: assert property (@(posedge clock) disable iff (!reset)
        resp_valid_o |=> !resp_valid_o);

endmodule

// File: axi_dcache.sv
module axi_dcache
    import axi_pkg::*;
    import cache_pkg::*;
(
    input  logic  clock,
    input  logic  reset,

    // refill request from the cache core
    input  logic  rd_valid_i,
    output logic  rd_ready_o,
    input  addr_t rd_addr_i,
    output logic  rd_beat_valid_o,
    output beat_t rd_data_o,
    output logic  rd_last_o,

    // write-back request from the cache core
    input  logic  wr_valid_i,
    output logic  wr_ready_o,
    input  addr_t wr_addr_i,
    input  line_t wr_line_i,

    input  logic  axi_aw_ready_i,
    output logic  axi_aw_valid_o,
    output addr_t axi_aw_addr_o,

    input  logic  axi_w_ready_i,
    output logic  axi_w_valid_o,
    output beat_t axi_w_data_o,
    output strb_t axi_w_strb_o,
    output logic  axi_w_last_o,

    input  logic  axi_b_valid_i,
    input  resp_t axi_b_resp_i,
    output logic  axi_b_ready_o,

    input  logic  axi_ar_ready_i,
    output logic  axi_ar_valid_o,
    output addr_t axi_ar_addr_o,

    input  logic  axi_r_valid_i,
    input  beat_t axi_r_data_i,
    input  logic  axi_r_last_i,
    input  resp_t axi_r_resp_i,
    output logic  axi_r_ready_o
);

    typedef enum logic [1:0] {
        w_idle,
        w_aw_wait,
        w_data,
        w_b_wait
    } wr_state_t;

    typedef enum logic [1:0] {
        r_idle,
        r_ar_wait,
        r_data
    } rd_state_t;

    wr_state_t w_state_q, w_state_d;
    rd_state_t r_state_q, r_state_d;
    beat_cnt_t w_cnt_q;
    addr_t     wr_addr_q;
    line_t     wr_line_q;
    addr_t     rd_addr_q;
    logic      wr_accept;
    logic      rd_accept;
    logic      w_last;

    assign wr_accept = (w_state_q == w_idle) && wr_valid_i;
    assign rd_accept = (r_state_q == r_idle) && rd_valid_i;
    assign w_last    = (w_state_q == w_data) && (w_cnt_q == beat_cnt_t'(BEATS_PER_LINE - 1));

    // write channel sends the address and four beats and then waits for B
    always_comb begin
        w_state_d = w_state_q;
        case (w_state_q)
            w_idle:    if (wr_valid_i) w_state_d = w_aw_wait;
            w_aw_wait: if (axi_aw_ready_i) w_state_d = w_data;
            w_data:    if (axi_w_ready_i && w_last) w_state_d = w_b_wait;
            w_b_wait:  if (axi_b_valid_i) w_state_d = w_idle;
            default:   w_state_d = w_idle;
        endcase
    end

    // read channel
    always_comb begin
        r_state_d = r_state_q;
        case (r_state_q)
            r_idle:    if (rd_valid_i) r_state_d = r_ar_wait;
            r_ar_wait: if (axi_ar_ready_i) r_state_d = r_data;
            r_data:    if (axi_r_valid_i && axi_r_last_i) r_state_d = r_idle;
            default:   r_state_d = r_idle;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            w_state_q <= w_idle;
            r_state_q <= r_idle;
            w_cnt_q   <= '0;
        end else begin
            w_state_q <= w_state_d;
            r_state_q <= r_state_d;
            if (wr_accept) begin
                w_cnt_q <= '0;
            end else if ((w_state_q == w_data) && axi_w_ready_i && !w_last) begin
                w_cnt_q <= w_cnt_q + 1'b1;  // next beat of the line
            end
        end
    end

    // latched request payload
    always_ff @(posedge clock) begin
        if (wr_accept) begin
            wr_addr_q <= wr_addr_i;
            wr_line_q <= wr_line_i;
        end
        if (rd_accept) begin
            rd_addr_q <= rd_addr_i;
        end
    end

    assign wr_ready_o      = (w_state_q == w_idle);   // high again once B is back
    assign rd_ready_o      = (r_state_q == r_idle);

    assign axi_aw_valid_o  = (w_state_q == w_aw_wait);
    assign axi_aw_addr_o   = wr_addr_q;
    assign axi_w_valid_o   = (w_state_q == w_data);
    assign axi_w_data_o    = wr_line_q[w_cnt_q*BEAT_BITS +: BEAT_BITS];
    assign axi_w_strb_o    = '1;                       // whole line on all lanes
    assign axi_w_last_o    = w_last;
    assign axi_b_ready_o   = (w_state_q == w_b_wait);

    assign axi_ar_valid_o  = (r_state_q == r_ar_wait);
    assign axi_ar_addr_o   = rd_addr_q;
    assign axi_r_ready_o   = (r_state_q == r_data);

    // beats go straight through to the core
    assign rd_beat_valid_o = axi_r_valid_i && axi_r_ready_o;
    assign rd_data_o       = axi_r_data_i;
    assign rd_last_o       = rd_beat_valid_o && axi_r_last_i;

    aw_valid_hold: assert property (@(posedge clock) disable iff (!reset)
        axi_aw_valid_o && !axi_aw_ready_i |=> axi_aw_valid_o);

    ar_valid_hold: assert property (@(posedge clock) disable iff (!reset)
        axi_ar_valid_o && !axi_ar_ready_i |=> axi_ar_valid_o);

    // every burst starts at beat 0 so last lands on the fourth beat
    w_last_on_fourth: assert property (@(posedge clock) disable iff (!reset)
        $rose(axi_w_valid_o) |-> w_cnt_q == '0);

    // the memory side is expected to answer OKAY on both channels
    b_resp_okay: assert property (@(posedge clock) disable iff (!reset)
        axi_b_valid_i && axi_b_ready_o |-> axi_b_resp_i == RESP_OKAY);

    r_resp_okay: assert property (@(posedge clock) disable iff (!reset)
        rd_beat_valid_o |-> axi_r_resp_i == RESP_OKAY);

endmodule

// File: cache_pkg.sv
package cache_pkg;

    // direct mapped, 16 lines of 32 bytes
    localparam int NUM_LINES  = 16;
    localparam int LINE_BITS  = 256;

    // address split into tag | index | word | byte
    localparam int TAG_BITS   = 23;
    localparam int INDEX_BITS = 4;
    localparam int WORD_BITS  = 2;
    localparam int TAG_LSB    = 9;
    localparam int INDEX_LSB  = 5;
    localparam int WORD_LSB   = 3;

    typedef logic [LINE_BITS-1:0]  line_t;
    typedef logic [TAG_BITS-1:0]   tag_t;    // addr[31:9]
    typedef logic [INDEX_BITS-1:0] index_t;  // addr[8:5]
    typedef logic [WORD_BITS-1:0]  word_t;   // addr[4:3]

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_wb_issue,    // hand the dirty victim to the bridge
        st_wb_wait,
        st_rf_issue,    // request the refill burst
        st_rf_wait,
        st_respond
    } ctrl_state_t;

endpackage

// File: axi_pkg.sv
package axi_pkg;

    // bus widths seen by the bridge and the memory side
    localparam int ADDR_BITS      = 32;
    localparam int BEAT_BITS      = 64;
    localparam int STRB_BITS      = BEAT_BITS / 8;
    localparam int RESP_BITS      = 2;

    // every burst is a fixed 4-beat INCR of full 8-byte beats
    localparam int BEATS_PER_LINE = 4;
    localparam int BEAT_CNT_BITS  = $clog2(BEATS_PER_LINE);

    typedef logic [ADDR_BITS-1:0]     addr_t;     // byte address
    typedef logic [BEAT_BITS-1:0]     beat_t;     // one data beat
    typedef logic [STRB_BITS-1:0]     strb_t;     // byte lanes of a beat
    typedef logic [RESP_BITS-1:0]     resp_t;
    typedef logic [BEAT_CNT_BITS-1:0] beat_cnt_t; // position inside a burst

    localparam resp_t RESP_OKAY = 2'b00;

endpackage
